// ==== csr_pkg.sv ====
// register widths, CSR address map, committed write and register view types
`default_nettype none

package csr_pkg;

  localparam int CSR_W        = 64;
  localparam int CSR_ADDR_W   = 12;
  // most instructions retired in one cycle, and the width of that count
  localparam int COMMIT_W     = 4;
  localparam int COMMIT_CNT_W = 3;
  // floating-point fields inside fcsr
  localparam int FFLAGS_W     = 5;
  localparam int FCSR_W       = 8;

  typedef logic [CSR_W-1:0] csr_data_t;

  typedef enum logic [CSR_ADDR_W-1:0] {
    FFLAGS   = 12'h001,
    FRM      = 12'h002,
    FCSR     = 12'h003,
    EVEC     = 12'h305,
    EPC      = 12'h502,
    BADVADDR = 12'h503,
    COUNT    = 12'h506,
    CAUSE    = 12'h509,
    STATUS   = 12'h50A,
    // read-only aliases and the hart id
    CYCLE    = 12'hC00,
    INSTRET  = 12'hC02,
    HARTID   = 12'hF14
  } csr_addr_e;

  // write released by the commit FSM, valid for one cycle
  typedef struct packed {
    logic      valid;
    csr_addr_e addr;
    csr_data_t data;
  } csr_wr_t;

  // current contents of every stored register
  typedef struct packed {
    logic [FCSR_W-1:0] fcsr;
    csr_data_t         epc;
    csr_data_t         badvaddr;
    csr_data_t         count;
    csr_data_t         evec;
    csr_data_t         cause;
    csr_data_t         status;
  } csr_view_t;

endpackage

`default_nettype wire

// ==== csr_trap_pkg.sv ====
// exception causes, status register layout, status masks and exception report type
`default_nettype none

package csr_trap_pkg;

  localparam int CAUSE_W = 4;

  typedef enum logic [CAUSE_W-1:0] {
    MISALIGNED_FETCH = 4'd0,
    FAULT_FETCH      = 4'd1,
    ILLEGAL          = 4'd2,
    MISALIGNED_LOAD  = 4'd4,
    FAULT_LOAD       = 4'd5,
    MISALIGNED_STORE = 4'd6,
    FAULT_STORE      = 4'd7
  } cause_e;

  // status bit positions
  localparam int SR_S      = 0;
  localparam int SR_PS     = 1;
  localparam int SR_EI     = 2;
  localparam int SR_PEI    = 3;
  localparam int SR_U64    = 5;
  localparam int SR_S64    = 6;
  localparam int SR_IM_LSB = 16;
  localparam int SR_IP_LSB = 24;
  localparam int SR_IRQ_W  = 8;

  localparam csr_pkg::csr_data_t SR_IM_MASK = 64'h0000_0000_00FF_0000;
  localparam csr_pkg::csr_data_t SR_IP_MASK = 64'h0000_0000_FF00_0000;

  localparam csr_pkg::csr_data_t STATUS_RESET =
    (64'd1 << SR_S) | (64'd1 << SR_U64) | (64'd1 << SR_S64);
  // low control bits plus the interrupt mask, IP is owned by hardware
  localparam csr_pkg::csr_data_t STATUS_WRITE_MASK = 64'h0000_0000_0000_01FF | SR_IM_MASK;

  typedef struct packed {
    logic               valid;
    cause_e             cause;
    csr_pkg::csr_data_t pc;
    csr_pkg::csr_data_t ld_addr;
    csr_pkg::csr_data_t st_addr;
  } exc_t;

endpackage

`default_nettype wire

// ==== csr_commit_ctrl.sv ====
// commit FSM that holds a CSR write until the instruction commits or is flushed
`default_nettype none
`timescale 1ns/1ps

module csr_commit_ctrl (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               wr_en_i,
  input  csr_pkg::csr_addr_e      wr_addr_i,
  input  csr_pkg::csr_data_t      wr_data_i,
  input  wire logic               commit_i,
  input  wire logic               flush_i,
  output csr_pkg::csr_wr_t        wr_o
);

  typedef enum logic {
    IDLE,
    WR_HELD
  } state_e;

  state_e             state_q;
  csr_pkg::csr_addr_e addr_q;
  csr_pkg::csr_data_t data_q;

  // a new write always wins, otherwise flush or commit releases the slot
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q <= IDLE;
    end
    else if (wr_en_i)
    begin
      state_q <= WR_HELD;
    end
    else if (flush_i || commit_i)
    begin
      state_q <= IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      addr_q <= wr_addr_i;
      data_q <= wr_data_i;
    end
  end

  // held write goes out in the commit cycle itself
  assign wr_o = '{valid: (state_q == WR_HELD) && commit_i, addr: addr_q, data: data_q};

  a_state_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(state_q))
    else $error("commit FSM state is unknown");

endmodule

`default_nettype wire

// ==== csr_retire_counter.sv ====
// count register advanced by retired instructions and reported exceptions
`default_nettype none
`timescale 1ns/1ps

module csr_retire_counter (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  csr_pkg::csr_wr_t                       wr_i,
  input  wire logic [csr_pkg::COMMIT_CNT_W-1:0]  total_commit_i,
  input  wire logic                              exc_valid_i,
  output csr_pkg::csr_data_t                     count_o
);

  csr_pkg::csr_data_t count_q;
  csr_pkg::csr_data_t count_inc;

  // an exception counts as one more retired slot
  assign count_inc = csr_pkg::csr_data_t'(total_commit_i) + csr_pkg::csr_data_t'(exc_valid_i);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count_q <= '0;
    end
    else if (wr_i.valid && (wr_i.addr == csr_pkg::COUNT))
    begin
      count_q <= wr_i.data;
    end
    else
    begin
      count_q <= count_q + count_inc;
    end
  end

  assign count_o = count_q;

  a_commit_range: assert property (@(posedge clk) disable iff (reset)
    total_commit_i <= csr_pkg::COMMIT_W)
    else $error("retire count %0d above commit width", total_commit_i);

endmodule

`default_nettype wire

// ==== csr_trap_regs.sv ====
// exception state registers epc, cause, badvaddr and the trap vector evec
`default_nettype none
`timescale 1ns/1ps

module csr_trap_regs (
  input  wire logic          clk,
  input  wire logic          reset,
  input  csr_pkg::csr_wr_t   wr_i,
  input  csr_trap_pkg::exc_t exc_i,
  input  wire logic          sret_i,
  output csr_pkg::csr_data_t epc_o,
  output csr_pkg::csr_data_t badvaddr_o,
  output csr_pkg::csr_data_t cause_o,
  output csr_pkg::csr_data_t evec_o
);

  csr_pkg::csr_data_t epc_q;
  csr_pkg::csr_data_t badvaddr_q;
  csr_pkg::csr_data_t cause_q;
  csr_pkg::csr_data_t evec_q;
  csr_pkg::csr_data_t badvaddr_d;

  // faulting address depends on where the exception came from
  always_comb
  begin
    badvaddr_d = badvaddr_q;
    if (exc_i.valid)
    begin
      case (exc_i.cause)
        csr_trap_pkg::MISALIGNED_FETCH,
        csr_trap_pkg::FAULT_FETCH:      badvaddr_d = exc_i.pc;
        csr_trap_pkg::MISALIGNED_LOAD,
        csr_trap_pkg::FAULT_LOAD:       badvaddr_d = exc_i.ld_addr;
        csr_trap_pkg::MISALIGNED_STORE,
        csr_trap_pkg::FAULT_STORE:      badvaddr_d = exc_i.st_addr;
        default:                        badvaddr_d = badvaddr_q;
      endcase
    end
  end

  // committed writes override the hardware update
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      epc_q      <= '0;
      badvaddr_q <= '0;
      cause_q    <= '0;
      evec_q     <= '0;
    end
    else
    begin
      if (wr_i.valid && (wr_i.addr == csr_pkg::EPC))
        epc_q <= wr_i.data;
      else if (exc_i.valid)
        epc_q <= exc_i.pc;

      if (wr_i.valid && (wr_i.addr == csr_pkg::CAUSE))
        cause_q <= wr_i.data;
      else if (exc_i.valid)
        cause_q <= csr_pkg::csr_data_t'(exc_i.cause);

      if (wr_i.valid && (wr_i.addr == csr_pkg::BADVADDR))
        badvaddr_q <= wr_i.data;
      else
        badvaddr_q <= badvaddr_d;

      if (wr_i.valid && (wr_i.addr == csr_pkg::EVEC))
        evec_q <= wr_i.data;
    end
  end

  assign epc_o      = epc_q;
  assign badvaddr_o = badvaddr_q;
  assign cause_o    = cause_q;
  assign evec_o     = evec_q;

  a_exc_sret_excl: assert property (@(posedge clk) disable iff (reset)
    !(exc_i.valid && sret_i))
    else $error("exception and sret reported in the same cycle");

endmodule

`default_nettype wire

// ==== csr_status_regs.sv ====
// status register with supervisor return, interrupt fields and pending output
`default_nettype none
`timescale 1ns/1ps

module csr_status_regs (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  csr_pkg::csr_wr_t                         wr_i,
  input  wire logic                                sret_i,
  input  wire logic [csr_trap_pkg::SR_IRQ_W-1:0]   irq_i,
  output csr_pkg::csr_data_t                       status_o,
  output logic                                     irq_pending_o
);

  csr_pkg::csr_data_t status_q;
  csr_pkg::csr_data_t status_d;
  logic [csr_trap_pkg::SR_IRQ_W-1:0] irq_active;

  always_comb
  begin
    status_d = status_q;
    if (wr_i.valid && (wr_i.addr == csr_pkg::STATUS))
    begin
      status_d = (wr_i.data & csr_trap_pkg::STATUS_WRITE_MASK) |
                 (status_q & csr_trap_pkg::SR_IP_MASK);
    end
    else if (sret_i)
    begin
      // restore previous mode and interrupt enable
      status_d[csr_trap_pkg::SR_S]  = status_q[csr_trap_pkg::SR_PS];
      status_d[csr_trap_pkg::SR_EI] = status_q[csr_trap_pkg::SR_PEI];
    end
    else
    begin
      status_d[csr_trap_pkg::SR_IP_LSB +: csr_trap_pkg::SR_IRQ_W] = irq_i;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      status_q <= csr_trap_pkg::STATUS_RESET;
    else
      status_q <= status_d;
  end

  // pending requests that are unmasked
  assign irq_active = status_q[csr_trap_pkg::SR_IP_LSB +: csr_trap_pkg::SR_IRQ_W] &
                      status_q[csr_trap_pkg::SR_IM_LSB +: csr_trap_pkg::SR_IRQ_W];

  assign irq_pending_o = status_q[csr_trap_pkg::SR_EI] && (|irq_active);
  assign status_o      = status_q;

endmodule

`default_nettype wire

// ==== csr_fp_regs.sv ====
// floating-point exception flags and rounding mode held as one fcsr byte
`default_nettype none
`timescale 1ns/1ps

module csr_fp_regs (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  csr_pkg::csr_wr_t                    wr_i,
  input  wire logic [csr_pkg::FFLAGS_W-1:0]   fflags_i,
  output logic [csr_pkg::FCSR_W-1:0]          fcsr_o
);

  logic [csr_pkg::FCSR_W-1:0] fcsr_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fcsr_q <= '0;
    end
    else if (wr_i.valid && (wr_i.addr == csr_pkg::FFLAGS))
    begin
      fcsr_q[csr_pkg::FFLAGS_W-1:0] <= wr_i.data[csr_pkg::FFLAGS_W-1:0];
    end
    else if (wr_i.valid && (wr_i.addr == csr_pkg::FRM))
    begin
      // rounding mode sits above the flags
      fcsr_q[csr_pkg::FCSR_W-1:csr_pkg::FFLAGS_W] <=
        wr_i.data[csr_pkg::FCSR_W-csr_pkg::FFLAGS_W-1:0];
    end
    else if (wr_i.valid && (wr_i.addr == csr_pkg::FCSR))
    begin
      fcsr_q <= wr_i.data[csr_pkg::FCSR_W-1:0];
    end
    else
    begin
      // sticky flags from retiring FP ops
      fcsr_q[csr_pkg::FFLAGS_W-1:0] <= fcsr_q[csr_pkg::FFLAGS_W-1:0] | fflags_i;
    end
  end

  assign fcsr_o = fcsr_q;

endmodule

`default_nettype wire

// ==== csr_read_check.sv ====
// read multiplexer, read checkpoint and atomicity violation flag
`default_nettype none
`timescale 1ns/1ps

module csr_read_check (
  input  wire logic          clk,
  input  wire logic          reset,
  input  csr_pkg::csr_view_t view_i,
  input  csr_pkg::csr_data_t hartid_i,
  input  wire logic          rd_en_i,
  input  wire logic          flush_i,
  input  wire logic          commit_i,
  input  csr_pkg::csr_addr_e rd_addr_i,
  output csr_pkg::csr_data_t rd_data_o,
  output logic               atomic_viol_o
);

  logic               chk_valid_q;
  csr_pkg::csr_addr_e chk_addr_q;
  csr_pkg::csr_data_t chk_data_q;
  csr_pkg::csr_data_t chk_cur;

  // shared by the live read and the checkpoint compare
  function automatic csr_pkg::csr_data_t csr_select(
    input csr_pkg::csr_addr_e addr,
    input csr_pkg::csr_view_t view,
    input csr_pkg::csr_data_t hartid
  );
    csr_pkg::csr_data_t value;
    case (addr)
      csr_pkg::FFLAGS:   value = csr_pkg::csr_data_t'(view.fcsr[csr_pkg::FFLAGS_W-1:0]);
      csr_pkg::FRM:
        value = csr_pkg::csr_data_t'(view.fcsr[csr_pkg::FCSR_W-1:csr_pkg::FFLAGS_W]);
      csr_pkg::FCSR:     value = csr_pkg::csr_data_t'(view.fcsr);
      csr_pkg::EVEC:     value = view.evec;
      csr_pkg::EPC:      value = view.epc;
      csr_pkg::BADVADDR: value = view.badvaddr;
      csr_pkg::CAUSE:    value = view.cause;
      csr_pkg::STATUS:   value = view.status;
      csr_pkg::COUNT,
      csr_pkg::CYCLE,
      csr_pkg::INSTRET:  value = view.count;
      csr_pkg::HARTID:   value = hartid;
      // unmapped reads return zero and so never mismatch
      default:           value = '0;
    endcase
    return value;
  endfunction

  assign rd_data_o = csr_select(rd_addr_i, view_i, hartid_i);

  // a fresh read wins over flush and commit
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      chk_valid_q <= 1'b0;
    else if (rd_en_i)
      chk_valid_q <= 1'b1;
    else if (flush_i || commit_i)
      chk_valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_addr_q <= rd_addr_i;
      chk_data_q <= rd_data_o;
    end
  end

  assign chk_cur       = csr_select(chk_addr_q, view_i, hartid_i);
  assign atomic_viol_o = chk_valid_q && (chk_cur != chk_data_q);

endmodule

`default_nettype wire

// ==== csr_file_top.sv ====
// CSR file top level joining commit control, counters, register groups and read check
`default_nettype none
`timescale 1ns/1ps

module csr_file_top (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                wr_en_i,
  input  csr_pkg::csr_addr_e                       wr_addr_i,
  input  csr_pkg::csr_data_t                       wr_data_i,
  input  wire logic                                commit_i,
  input  wire logic                                flush_i,
  input  wire logic                                rd_en_i,
  input  csr_pkg::csr_addr_e                       rd_addr_i,
  input  wire logic [csr_pkg::COMMIT_CNT_W-1:0]    total_commit_i,
  input  wire logic                                exc_valid_i,
  input  csr_trap_pkg::cause_e                     exc_cause_i,
  input  csr_pkg::csr_data_t                       exc_pc_i,
  input  csr_pkg::csr_data_t                       ld_addr_i,
  input  csr_pkg::csr_data_t                       st_addr_i,
  input  wire logic                                sret_i,
  input  wire logic [csr_pkg::FFLAGS_W-1:0]        fflags_i,
  input  wire logic [csr_trap_pkg::SR_IRQ_W-1:0]   irq_i,
  input  csr_pkg::csr_data_t                       hartid_i,
  output csr_pkg::csr_data_t                       rd_data_o,
  output logic                                     atomic_viol_o,
  output logic                                     irq_pending_o,
  output csr_pkg::csr_data_t                       epc_o,
  output csr_pkg::csr_data_t                       evec_o,
  output csr_pkg::csr_data_t                       status_o,
  output csr_pkg::csr_data_t                       frm_o
);

  csr_pkg::csr_wr_t            wr;
  csr_trap_pkg::exc_t          exc;
  csr_pkg::csr_view_t          view;
  logic [csr_pkg::FCSR_W-1:0]  fcsr;
  csr_pkg::csr_data_t          epc;
  csr_pkg::csr_data_t          badvaddr;
  csr_pkg::csr_data_t          count;
  csr_pkg::csr_data_t          evec;
  csr_pkg::csr_data_t          cause;
  csr_pkg::csr_data_t          status;

  assign exc = '{valid: exc_valid_i, cause: exc_cause_i, pc: exc_pc_i,
                 ld_addr: ld_addr_i, st_addr: st_addr_i};

  assign view = '{fcsr: fcsr, epc: epc, badvaddr: badvaddr, count: count,
                  evec: evec, cause: cause, status: status};

  csr_commit_ctrl u_commit_ctrl (
    .clk       (clk),
    .reset     (reset),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .commit_i  (commit_i),
    .flush_i   (flush_i),
    .wr_o      (wr)
  );

  csr_retire_counter u_retire_counter (
    .clk            (clk),
    .reset          (reset),
    .wr_i           (wr),
    .total_commit_i (total_commit_i),
    .exc_valid_i    (exc_valid_i),
    .count_o        (count)
  );

  csr_trap_regs u_trap_regs (
    .clk        (clk),
    .reset      (reset),
    .wr_i       (wr),
    .exc_i      (exc),
    .sret_i     (sret_i),
    .epc_o      (epc),
    .badvaddr_o (badvaddr),
    .cause_o    (cause),
    .evec_o     (evec)
  );

  csr_status_regs u_status_regs (
    .clk           (clk),
    .reset         (reset),
    .wr_i          (wr),
    .sret_i        (sret_i),
    .irq_i         (irq_i),
    .status_o      (status),
    .irq_pending_o (irq_pending_o)
  );

  csr_fp_regs u_fp_regs (
    .clk      (clk),
    .reset    (reset),
    .wr_i     (wr),
    .fflags_i (fflags_i),
    .fcsr_o   (fcsr)
  );

  csr_read_check u_read_check (
    .clk           (clk),
    .reset         (reset),
    .view_i        (view),
    .hartid_i      (hartid_i),
    .rd_en_i       (rd_en_i),
    .flush_i       (flush_i),
    .commit_i      (commit_i),
    .rd_addr_i     (rd_addr_i),
    .rd_data_o     (rd_data_o),
    .atomic_viol_o (atomic_viol_o)
  );

  assign epc_o    = epc;
  assign evec_o   = evec;
  assign status_o = status;
  // rounding mode for the FP units, zero-extended
  assign frm_o    = csr_pkg::csr_data_t'(fcsr[csr_pkg::FCSR_W-1:csr_pkg::FFLAGS_W]);

endmodule

`default_nettype wire

// ==== tb_csr_file.sv ====
// directed testbench for the CSR file with typed compare tasks and a watchdog
`default_nettype none
`timescale 1ns/1ps

module tb_csr_file;

  localparam int CLK_PERIOD = 8;
  // reset, reset values, commit, fp fields, exceptions, status, atomicity
  localparam int TEST_CYCLES = 5 + 14 + 12 + 18 + 42 + 16 + 16;
  localparam int MARGIN_CYCLES = 100;
  localparam int WATCHDOG_NS = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
  localparam csr_pkg::csr_data_t HART = 64'h0000_0000_0000_0003;
  // S, U64 and S64 set
  localparam csr_pkg::csr_data_t ST_RESET = 64'h0000_0000_0000_0061;

  logic                 clk;
  logic                 reset;
  logic                 wr_en;
  csr_pkg::csr_addr_e   wr_addr;
  csr_pkg::csr_data_t   wr_data;
  logic                 commit;
  logic                 flush;
  logic                 rd_en;
  csr_pkg::csr_addr_e   rd_addr;
  logic [2:0]           total_commit;
  logic                 exc_valid;
  csr_trap_pkg::cause_e exc_cause;
  csr_pkg::csr_data_t   exc_pc;
  csr_pkg::csr_data_t   ld_addr;
  csr_pkg::csr_data_t   st_addr;
  logic                 sret;
  logic [4:0]           fflags;
  logic [7:0]           irq;
  csr_pkg::csr_data_t   hartid;
  csr_pkg::csr_data_t   rd_data;
  logic                 atomic_viol;
  logic                 irq_pending;
  csr_pkg::csr_data_t   epc;
  csr_pkg::csr_data_t   evec;
  csr_pkg::csr_data_t   status;
  csr_pkg::csr_data_t   frm;

  integer             seed = 32'h29db_2a67;
  int                 n_checks;
  int                 n_errors;
  csr_pkg::csr_data_t exp_count;

  csr_file_top UUT (
    .clk (clk), .reset (reset), .wr_en_i (wr_en), .wr_addr_i (wr_addr),
    .wr_data_i (wr_data), .commit_i (commit), .flush_i (flush), .rd_en_i (rd_en),
    .rd_addr_i (rd_addr), .total_commit_i (total_commit), .exc_valid_i (exc_valid),
    .exc_cause_i (exc_cause), .exc_pc_i (exc_pc), .ld_addr_i (ld_addr),
    .st_addr_i (st_addr), .sret_i (sret), .fflags_i (fflags), .irq_i (irq),
    .hartid_i (hartid), .rd_data_o (rd_data), .atomic_viol_o (atomic_viol),
    .irq_pending_o (irq_pending), .epc_o (epc), .evec_o (evec), .status_o (status),
    .frm_o (frm)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish in time");
    $display("Something failed");
    $finish;
  end

  task automatic check_data(input string name, input csr_pkg::csr_data_t got,
                            input csr_pkg::csr_data_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_fcsr(input string name, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic read_expect(input csr_pkg::csr_addr_e addr, input csr_pkg::csr_data_t exp,
                             input string name);
    @(posedge clk);
    rd_addr <= addr;
    @(negedge clk);
    check_data(name, rd_data, exp);
  endtask

  // issue a write and commit it on the following cycle
  task automatic csr_write(input csr_pkg::csr_addr_e addr, input csr_pkg::csr_data_t data);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk);
    wr_en  <= 1'b0;
    commit <= 1'b1;
    @(posedge clk);
    commit <= 1'b0;
  endtask

  task automatic raise_exc(input csr_trap_pkg::cause_e cause, input csr_pkg::csr_data_t pc,
                           input csr_pkg::csr_data_t ld, input csr_pkg::csr_data_t st,
                           input logic [2:0] tc);
    @(posedge clk);
    exc_valid    <= 1'b1;
    exc_cause    <= cause;
    exc_pc       <= pc;
    ld_addr      <= ld;
    st_addr      <= st;
    total_commit <= tc;
    @(posedge clk);
    exc_valid    <= 1'b0;
    total_commit <= 3'd0;
  endtask

  task automatic reset_values();
    exp_count = 64'd0;
    read_expect(csr_pkg::FFLAGS, 64'd0, "fflags");
    read_expect(csr_pkg::FRM, 64'd0, "frm");
    read_expect(csr_pkg::FCSR, 64'd0, "fcsr");
    read_expect(csr_pkg::EVEC, 64'd0, "evec");
    read_expect(csr_pkg::EPC, 64'd0, "epc");
    read_expect(csr_pkg::BADVADDR, 64'd0, "badvaddr");
    read_expect(csr_pkg::COUNT, 64'd0, "count");
    read_expect(csr_pkg::CAUSE, 64'd0, "cause");
    read_expect(csr_pkg::CYCLE, 64'd0, "cycle");
    read_expect(csr_pkg::INSTRET, 64'd0, "instret");
    read_expect(csr_pkg::STATUS, ST_RESET, "status");
    read_expect(csr_pkg::HARTID, HART, "hartid");
    read_expect(csr_pkg::csr_addr_e'(12'h7FF), 64'd0, "unknown address");
    check_flag("atomic_viol_o", atomic_viol, 1'b0);
    check_flag("irq_pending_o", irq_pending, 1'b0);
  endtask

  task automatic commit_discipline();
    csr_pkg::csr_data_t data;
    data = {$random(seed), $random(seed)};
    @(posedge clk);
    rd_addr <= csr_pkg::EVEC;
    wr_en   <= 1'b1;
    wr_addr <= csr_pkg::EVEC;
    wr_data <= data;
    @(posedge clk);
    wr_en <= 1'b0;
    @(negedge clk);
    check_data("evec held", rd_data, 64'd0);
    @(posedge clk);
    commit <= 1'b1;
    @(negedge clk);
    check_data("evec in commit cycle", rd_data, 64'd0);
    @(posedge clk);
    commit <= 1'b0;
    @(negedge clk);
    check_data("evec committed", rd_data, data);
    check_data("evec_o", evec, data);
    // flushed write must be lost
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_data <= ~data;
    @(posedge clk);
    wr_en <= 1'b0;
    flush <= 1'b1;
    @(posedge clk);
    flush  <= 1'b0;
    commit <= 1'b1;
    @(posedge clk);
    commit <= 1'b0;
    @(negedge clk);
    check_data("evec after flush", rd_data, data);
    check_data("evec_o after flush", evec, data);
  endtask

  task automatic fp_field_updates();
    // overlapping flag bits so that OR differs from add and from replace
    @(posedge clk);
    fflags <= 5'h03;
    @(posedge clk);
    fflags <= 5'h06;
    @(posedge clk);
    fflags <= 5'h00;
    read_expect(csr_pkg::FFLAGS, 64'h07, "fflags accumulated");
    csr_write(csr_pkg::FRM, 64'h6);
    @(negedge clk);
    check_data("frm_o", frm, 64'h6);
    read_expect(csr_pkg::FCSR, 64'hC7, "fcsr after frm write");
    check_fcsr("fcsr byte", rd_data[7:0], 8'hC7);
    read_expect(csr_pkg::FFLAGS, 64'h07, "fflags after frm write");
    csr_write(csr_pkg::FCSR, 64'h3A);
    read_expect(csr_pkg::FCSR, 64'h3A, "fcsr after fcsr write");
    check_fcsr("fcsr byte", rd_data[7:0], 8'h3A);
    read_expect(csr_pkg::FRM, 64'h1, "frm after fcsr write");
    read_expect(csr_pkg::FFLAGS, 64'h1A, "fflags after fcsr write");
  endtask

  task automatic exception_capture();
    csr_trap_pkg::cause_e causes [7];
    csr_pkg::csr_data_t   pc;
    csr_pkg::csr_data_t   ld;
    csr_pkg::csr_data_t   st;
    csr_pkg::csr_data_t   exp_bad;
    logic [2:0]           tc;
    causes = '{csr_trap_pkg::MISALIGNED_FETCH, csr_trap_pkg::FAULT_FETCH,
               csr_trap_pkg::ILLEGAL, csr_trap_pkg::MISALIGNED_LOAD, csr_trap_pkg::FAULT_LOAD,
               csr_trap_pkg::MISALIGNED_STORE, csr_trap_pkg::FAULT_STORE};
    exp_bad = 64'd0;
    for (int i = 0; i < 7; i++)
    begin
      pc = {$random(seed), $random(seed)};
      ld = {$random(seed), $random(seed)};
      st = {$random(seed), $random(seed)};
      tc = 3'(i % 5);
      raise_exc(causes[i], pc, ld, st, tc);
      exp_count = exp_count + csr_pkg::csr_data_t'(tc) + 64'd1;
      // fetch, load and store causes pick their own faulting address
      case (causes[i])
        csr_trap_pkg::MISALIGNED_FETCH, csr_trap_pkg::FAULT_FETCH: exp_bad = pc;
        csr_trap_pkg::MISALIGNED_LOAD, csr_trap_pkg::FAULT_LOAD:   exp_bad = ld;
        csr_trap_pkg::MISALIGNED_STORE, csr_trap_pkg::FAULT_STORE: exp_bad = st;
        default:                                                   exp_bad = exp_bad;
      endcase
      read_expect(csr_pkg::EPC, pc, "epc");
      check_data("epc_o", epc, pc);
      read_expect(csr_pkg::CAUSE, csr_pkg::csr_data_t'(causes[i]), "cause");
      read_expect(csr_pkg::BADVADDR, exp_bad, "badvaddr");
    end
    @(posedge clk);
    total_commit <= 3'd3;
    repeat (2) @(posedge clk);
    total_commit <= 3'd0;
    exp_count = exp_count + 64'd6;
    read_expect(csr_pkg::COUNT, exp_count, "count");
    read_expect(csr_pkg::CYCLE, exp_count, "cycle");
    read_expect(csr_pkg::INSTRET, exp_count, "instret");
  endtask

  task automatic status_updates();
    @(posedge clk);
    irq <= 8'h10;
    // IP bits in the data are masked off
    csr_write(csr_pkg::STATUS, 64'hAAAA_5555_FF0F_000E);
    @(negedge clk);
    check_data("status_o after write", status, 64'h0000_0000_100F_000E);
    check_flag("irq_pending_o unmatched", irq_pending, 1'b0);
    @(posedge clk);
    irq <= 8'h14;
    @(posedge clk);
    @(negedge clk);
    check_data("status_o with irq", status, 64'h0000_0000_140F_000E);
    check_flag("irq_pending_o matched", irq_pending, 1'b1);
    csr_write(csr_pkg::STATUS, 64'h0000_0000_000F_000A);
    @(negedge clk);
    check_data("status_o ei clear", status, 64'h0000_0000_140F_000A);
    check_flag("irq_pending_o ei clear", irq_pending, 1'b0);
    @(posedge clk);
    sret <= 1'b1;
    @(posedge clk);
    sret <= 1'b0;
    @(negedge clk);
    check_data("status_o after sret", status, 64'h0000_0000_140F_000F);
    check_flag("irq_pending_o after sret", irq_pending, 1'b1);
  endtask

  task automatic atomic_read_guard();
    @(posedge clk);
    rd_en   <= 1'b1;
    rd_addr <= csr_pkg::EPC;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    check_flag("atomic_viol_o unchanged epc", atomic_viol, 1'b0);
    raise_exc(csr_trap_pkg::ILLEGAL, ~epc, 64'd0, 64'd0, 3'd0);
    @(negedge clk);
    check_flag("atomic_viol_o epc changed", atomic_viol, 1'b1);
    @(posedge clk);
    commit <= 1'b1;
    @(posedge clk);
    commit <= 1'b0;
    @(negedge clk);
    check_flag("atomic_viol_o after commit", atomic_viol, 1'b0);
    // evec is untouched by the exception
    @(posedge clk);
    rd_en   <= 1'b1;
    rd_addr <= csr_pkg::EVEC;
    @(posedge clk);
    rd_en <= 1'b0;
    raise_exc(csr_trap_pkg::FAULT_LOAD, ~epc, 64'h1000, 64'd0, 3'd1);
    @(negedge clk);
    check_flag("atomic_viol_o unchanged evec", atomic_viol, 1'b0);
  endtask

  initial
  begin
    n_checks     = 0;
    n_errors     = 0;
    reset        = 1'b1;
    wr_en        = 1'b0;
    wr_addr      = csr_pkg::FFLAGS;
    wr_data      = 64'd0;
    commit       = 1'b0;
    flush        = 1'b0;
    rd_en        = 1'b0;
    rd_addr      = csr_pkg::FFLAGS;
    total_commit = 3'd0;
    exc_valid    = 1'b0;
    exc_cause    = csr_trap_pkg::MISALIGNED_FETCH;
    exc_pc       = 64'd0;
    ld_addr      = 64'd0;
    st_addr      = 64'd0;
    sret         = 1'b0;
    fflags       = 5'd0;
    irq          = 8'd0;
    hartid       = HART;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    reset_values();
    commit_discipline();
    fp_field_updates();
    exception_capture();
    status_updates();
    atomic_read_guard();
    @(posedge clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
csr_pkg.sv
csr_trap_pkg.sv
csr_commit_ctrl.sv
csr_retire_counter.sv
csr_trap_regs.sv
csr_status_regs.sv
csr_fp_regs.sv
csr_read_check.sv
csr_file_top.sv
tb_csr_file.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module tb_csr_file -f flist.f -o sim_csr

run: build
	./obj_dir/sim_csr > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --top-module csr_file_top \
		csr_pkg.sv csr_trap_pkg.sv csr_commit_ctrl.sv csr_retire_counter.sv \
		csr_trap_regs.sv csr_status_regs.sv csr_fp_regs.sv csr_read_check.sv \
		csr_file_top.sv

clean:
	rm -rf obj_dir sim.log
